// File: icache_top.f
rtl/icache_pkg.sv
rtl/icache_array_if.sv
rtl/icache_way_ram.sv
rtl/icache_ways.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/icache_checker.sv
tb/icache_tb.sv

// File: rtl/icache_array_if.sv
// array port between the cache controller and the way RAMs
`timescale 1ns/1ns

interface icache_array_if #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
);
  import icache_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumSets);
  localparam int unsigned TagWidth = AddrWidth - IdxWidth - OffsetWidth;
  localparam int unsigned WordBits = $clog2(WordsPerLine);

  // set select, shared by reads, fills and the flush sweep
  logic [IdxWidth-1:0] index;
  // read all ways at index
  logic                rd_en;
  // tag/valid write, only to the ways flagged in tag_way_oh
  logic                tag_we;
  logic [NumWays-1:0]  tag_way_oh;
  logic [TagWidth-1:0] tag_wdata;
  // 1 on a fill, 0 while sweeping
  logic                vld_wdata;
  logic                line_we;
  // word inside the line, used in the compare cycle
  logic [WordBits-1:0] offset;

  // compare results from the way side
  logic                hit;
  word_t               hit_word;
  logic [NumWays-1:0]  vld_rdata;

  modport ctrl (
    output index, rd_en, tag_we, tag_way_oh, tag_wdata, vld_wdata, line_we, offset,
    input  hit, hit_word, vld_rdata
  );

  modport ways (
    input  index, rd_en, tag_we, tag_way_oh, tag_wdata, vld_wdata, line_we, offset,
    output hit, hit_word, vld_rdata
  );

endinterface

// File: rtl/icache_ctrl.sv
// cache controller with request capture, fetch FSM, flush sweep, replacement and refill request
`timescale 1ns/1ns

module icache_ctrl #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic              flush_i,
  input  logic              req_i,
  input  icache_pkg::addr_t addr_i,
  output logic              ready_o,
  output logic              valid_o,
  output icache_pkg::word_t data_o,
  output logic              miss_o,
  output logic              mem_req_o,
  output icache_pkg::addr_t mem_addr_o,
  output logic              mem_nc_o,
  input  logic              mem_ack_i,
  input  logic              mem_rtrn_vld_i,
  input  icache_pkg::line_t mem_rtrn_data_i,
  output logic [icache_pkg::AddrWidth-$clog2(NumSets)-icache_pkg::OffsetWidth-1:0] tag_o,
  icache_array_if.ctrl      arr
);
  import icache_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumSets);
  localparam int unsigned WayWidth = $clog2(NumWays);
  localparam int unsigned WordBits = $clog2(WordsPerLine);

  typedef enum logic [2:0] {FLUSH, IDLE, READ, MISS_REQ, MISS_WAIT} state_e;

  state_e              state_d, state_q;
  addr_t               addr_q;
  logic [WordBits-1:0] word_sel;
  logic                accept;
  logic                nc_d, nc_q;
  logic                en_d, en_q;
  logic                flush_d, flush_q;
  logic                need_flush;
  logic [IdxWidth-1:0] flush_cnt_d, flush_cnt_q;
  logic                flush_done;
  logic                fill;
  // replacement
  logic [NumWays-1:0]  inv_oh, rnd_oh, repl_oh_d, repl_oh_q;
  logic                all_vld, all_vld_q;
  logic [3:0]          lfsr_q;

  ////////////////////////////////////////////////////////////////////////////
  // address split and refill request
  ////////////////////////////////////////////////////////////////////////////

  assign tag_o    = addr_q[AddrWidth-1:OffsetWidth+IdxWidth];
  assign word_sel = addr_q[OffsetWidth-1:OffsetWidth-WordBits];
  // disabled cache treats every fetch as i/o
  assign nc_d     = ~en_q | is_noncacheable(addr_i);

  // word address for i/o, line address otherwise
  assign mem_addr_o = nc_q ? {addr_q[AddrWidth-1:2], 2'b00}
                           : {addr_q[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  assign mem_nc_o   = nc_q;

  // refill word sits at the same offset for both kinds of return
  assign data_o = (state_q == MISS_WAIT) ? mem_rtrn_data_i[word_sel*WordWidth +: WordWidth]
                                         : arr.hit_word;

  // pending flush, or a sweep on the rising enable
  assign need_flush = flush_q | flush_i | (en_i & ~en_q);

  ////////////////////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d   = state_q;
    // disable is immediate, enable waits for the sweep
    en_d      = en_q & en_i;
    flush_d   = flush_q | flush_i;
    ready_o   = 1'b0;
    valid_o   = 1'b0;
    miss_o    = 1'b0;
    mem_req_o = 1'b0;
    accept    = 1'b0;
    fill      = 1'b0;
    unique case (state_q)
      FLUSH: begin
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
          en_d    = en_i;
        end
      end
      IDLE: begin
        if (need_flush) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            accept  = 1'b1;
            state_d = READ;
          end
        end
      end
      // compare cycle, arrays were read in the accept cycle
      READ: begin
        if (!nc_q && arr.hit) begin
          valid_o = 1'b1;
          ready_o = ~need_flush;
          state_d = IDLE;
          // stream the next request straight into another compare
          if (req_i && !need_flush) begin
            accept  = 1'b1;
            state_d = READ;
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS_WAIT;
          end else begin
            state_d = MISS_REQ;
          end
        end
      end
      // hold the request until memory takes it
      MISS_REQ: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          miss_o  = ~nc_q;
          state_d = MISS_WAIT;
        end
      end
      // the return beat is never stalled
      MISS_WAIT: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          fill    = ~nc_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // array control, flush sweep and replacement
  ////////////////////////////////////////////////////////////////////////////

  assign flush_done  = (state_q == FLUSH) && (flush_cnt_q == IdxWidth'(NumSets - 1));
  assign flush_cnt_d = flush_done          ? '0 :
                       (state_q == FLUSH)  ? flush_cnt_q + 1'b1 :
                                             flush_cnt_q;

  assign arr.offset = word_sel;

  always_comb begin : p_array
    arr.index      = addr_q[OffsetWidth +: IdxWidth];
    arr.rd_en      = accept;
    arr.tag_we     = fill;
    arr.tag_way_oh = repl_oh_q;
    arr.tag_wdata  = tag_o;
    arr.vld_wdata  = 1'b1;
    arr.line_we    = fill;
    if (state_q == FLUSH) begin
      // clear one set per cycle in every way
      arr.index      = flush_cnt_q;
      arr.tag_we     = 1'b1;
      arr.tag_way_oh = '1;
      arr.tag_wdata  = '0;
      arr.vld_wdata  = 1'b0;
    end else if (accept) begin
      arr.index = addr_i[OffsetWidth +: IdxWidth];
    end
  end

  // first invalid way, lowest index first
  always_comb begin : p_inv_way
    inv_oh = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!arr.vld_rdata[i]) begin
        inv_oh    = '0;
        inv_oh[i] = 1'b1;
      end
    end
  end

  assign all_vld   = &arr.vld_rdata;
  assign rnd_oh    = NumWays'(1) << lfsr_q[WayWidth-1:0];
  // victim is fixed in the compare cycle and held until the fill
  assign repl_oh_d = (state_q == READ) ? (all_vld ? rnd_oh : inv_oh) : repl_oh_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      nc_q        <= 1'b0;
      en_q        <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      repl_oh_q   <= '0;
      all_vld_q   <= 1'b0;
      lfsr_q      <= 4'b0001;
    end else begin
      state_q     <= state_d;
      en_q        <= en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      repl_oh_q   <= repl_oh_d;
      if (accept) begin
        nc_q <= nc_d;
      end
      if (state_q == READ) begin
        all_vld_q <= all_vld;
      end
      // x^4 + x^3 + 1, steps only on random replacement
      if (fill && all_vld_q) begin
        lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_addr
    if (accept) begin
      addr_q <= addr_i;
    end
  end

endmodule

// File: rtl/icache_pkg.sv
// instruction cache package with fixed widths, payload types and the cacheability rule
package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // fixed widths
  ////////////////////////////////////////////////////////////////////////////

  // physical fetch address
  localparam int unsigned AddrWidth    = 32;
  // one fetch word handed to the core
  localparam int unsigned WordWidth    = 32;
  // a full line, returned by memory in a single beat
  localparam int unsigned LineWidth    = 128;
  localparam int unsigned WordsPerLine = LineWidth / WordWidth;
  // byte offset inside a line
  localparam int unsigned OffsetWidth  = $clog2(LineWidth / 8);

  ////////////////////////////////////////////////////////////////////////////
  // payload types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [WordWidth-1:0] word_t;
  typedef logic [LineWidth-1:0] line_t;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  // upper half of the address space is the i/o region
  // fetches there bypass the arrays
  function automatic logic is_noncacheable(input addr_t addr);
    return addr[AddrWidth-1];
  endfunction

endpackage

// File: rtl/icache_top.sv
// set-associative instruction cache top with core and refill ports
`timescale 1ns/1ns

module icache_top #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // core side
  input  logic              req_i,
  input  icache_pkg::addr_t addr_i,
  output logic              ready_o,
  output logic              valid_o,
  output icache_pkg::word_t data_o,
  input  logic              en_i,
  input  logic              flush_i,
  output logic              miss_o,
  // memory side
  output logic              mem_req_o,
  output icache_pkg::addr_t mem_addr_o,
  output logic              mem_nc_o,
  input  logic              mem_ack_i,
  input  logic              mem_rtrn_vld_i,
  input  icache_pkg::line_t mem_rtrn_data_i
);
  import icache_pkg::*;

  localparam int unsigned TagWidth = AddrWidth - $clog2(NumSets) - OffsetWidth;

  // tag of the request in the compare cycle
  logic [TagWidth-1:0] tag;

  icache_array_if #(.NumWays(NumWays), .NumSets(NumSets)) arr ();

  ////////////////////////////////////////////////////////////////////////////
  // controller and arrays
  ////////////////////////////////////////////////////////////////////////////

  icache_ctrl #(.NumWays(NumWays), .NumSets(NumSets)) i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .tag_o           (tag),
    .arr             (arr.ctrl)
  );

  // refill line goes straight into the chosen way
  icache_ways #(.NumWays(NumWays), .NumSets(NumSets)) i_ways (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .arr         (arr.ways),
    .rtrn_line_i (mem_rtrn_data_i),
    .tag_i       (tag)
  );

endmodule

// File: rtl/icache_way_ram.sv
// single-port synchronous RAM with a one-cycle read, entry type chosen per instance
`timescale 1ns/1ns

module icache_way_ram #(
  parameter int unsigned Depth   = 64,
  parameter type         entry_t = logic
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  // storage array
  entry_t mem_q [Depth];

  // one access per cycle
  // a write leaves the read port holding the last read entry
  always_ff @(posedge clk_i) begin : p_ram
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: rtl/icache_ways.sv
// cache way arrays with tag compare, hit way select and fetch word select
`timescale 1ns/1ns

module icache_ways #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 64
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  icache_array_if.ways      arr,
  input  icache_pkg::line_t rtrn_line_i,
  input  logic [icache_pkg::AddrWidth-$clog2(NumSets)-icache_pkg::OffsetWidth-1:0] tag_i
);
  import icache_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumSets);
  localparam int unsigned TagWidth = AddrWidth - IdxWidth - OffsetWidth;

  // valid bit kept next to the tag
  typedef struct packed {
    logic                vld;
    logic [TagWidth-1:0] tag;
  } tag_entry_t;

  tag_entry_t         tag_wdata;
  tag_entry_t         tag_rdata  [NumWays];
  line_t              line_rdata [NumWays];
  word_t              way_word   [NumWays];
  logic [NumWays-1:0] vld;
  logic [NumWays-1:0] match;
  // rdata is fresh in the cycle after a read
  logic               rd_q;

  assign tag_wdata = '{vld: arr.vld_wdata, tag: arr.tag_wdata};

  ////////////////////////////////////////////////////////////////////////////
  // per-way storage and compare
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumWays; i++) begin : gen_way
    logic tag_wr;
    logic line_wr;

    assign tag_wr  = arr.tag_we & arr.tag_way_oh[i];
    assign line_wr = arr.line_we & arr.tag_way_oh[i];

    icache_way_ram #(.Depth(NumSets), .entry_t(tag_entry_t)) i_tag_ram (
      .clk_i   (clk_i),
      .req_i   (arr.rd_en | tag_wr),
      .we_i    (tag_wr),
      .addr_i  (arr.index),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[i])
    );

    icache_way_ram #(.Depth(NumSets), .entry_t(line_t)) i_line_ram (
      .clk_i   (clk_i),
      .req_i   (arr.rd_en | line_wr),
      .we_i    (line_wr),
      .addr_i  (arr.index),
      .wdata_i (rtrn_line_i),
      .rdata_o (line_rdata[i])
    );

    assign vld[i]      = tag_rdata[i].vld;
    assign match[i]    = rd_q & tag_rdata[i].vld & (tag_rdata[i].tag == tag_i);
    // word picked out of each way before the hit mux
    assign way_word[i] = line_rdata[i][arr.offset*WordWidth +: WordWidth];
  end

  assign arr.vld_rdata = vld;
  assign arr.hit       = |match;

  // lowest hitting way wins
  always_comb begin : p_hit_sel
    arr.hit_word = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (match[i]) begin
        arr.hit_word = way_word[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rd
    if (!rst_ni) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= arr.rd_en;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module icache_tb -f icache_top.f -o icache_sim \
  && ./obj_dir/icache_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1

// File: tb/icache_checker.sv
// fetch response checker comparing the core and refill ports with the memory word rule
`timescale 1ns/1ns

module icache_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_i,
  input icache_pkg::addr_t addr_i,
  input logic              ready_i,
  input logic              valid_i,
  input icache_pkg::word_t data_i,
  input logic              miss_i,
  input logic              mem_req_i,
  input icache_pkg::addr_t mem_addr_i,
  input logic              mem_nc_i,
  input logic              mem_ack_i
);
  import icache_pkg::*;

  typedef struct packed {
    logic miss;
    logic nc;
  } exp_t;

  // expectations not yet accepted, then fetches in flight
  exp_t         pend_q     [$];
  addr_t        fl_addr_q  [$];
  exp_t         fl_exp_q   [$];
  int           fl_cycle_q [$];
  int           cycle       = 0;
  int           outstanding = 0;
  logic         req_seen    = 1'b0;
  logic         miss_seen   = 1'b0;
  logic [127:0] test_name   = '0;
  int           test_checks = 0;
  int           test_errors = 0;
  int           num_tests   = 0;
  int           num_failed  = 0;
  int           check_count = 0;
  int           error_count = 0;

  // memory holds each word as its byte address xor a fixed pattern
  function automatic word_t word_at(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  task automatic expect_fetch(input logic miss, input logic nc);
    pend_q.push_back('{miss: miss, nc: nc});
    outstanding++;
  endtask

  task automatic start_test(input logic [127:0] name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    num_tests++;
    if (test_errors != 0) begin
      num_failed++;
    end
    $display("test %0s: %0s, %0d checks, %0d errors", test_name,
             (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
  endtask

  task automatic report();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             num_tests, num_failed, check_count, error_count);
  endtask

  task automatic compare(input string sig, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    test_checks++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, sig, got, exp);
    end
  endtask

  task automatic complain(input string msg);
    error_count++;
    test_errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // port monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : p_watch
    exp_t  e;
    addr_t a;
    int    t;
    if (!rst_ni) begin
      // quiet outputs while reset is held
      compare("ready_o", 32'(ready_i), 32'd0);
      compare("valid_o", 32'(valid_i), 32'd0);
      compare("mem_req_o", 32'(mem_req_i), 32'd0);
      compare("miss_o", 32'(miss_i), 32'd0);
    end else begin
      cycle++;
      // a response retires the oldest fetch
      if (valid_i) begin
        if (fl_addr_q.size() == 0) begin
          complain("valid_o rose with no fetch in flight");
        end else begin
          a = fl_addr_q.pop_front();
          e = fl_exp_q.pop_front();
          t = fl_cycle_q.pop_front();
          compare("data_o", data_i, word_at(a));
          compare("miss_o", 32'(miss_seen), 32'(e.miss));
          compare("mem_req_o", 32'(req_seen), 32'(e.miss | e.nc));
          // hit answers one cycle after acceptance
          if (!e.miss && !e.nc) begin
            compare("valid_o latency", cycle - t, 32'd1);
            // the next request may enter in the same cycle
            compare("ready_o", 32'(ready_i), 32'd1);
          end
          outstanding--;
        end
        req_seen  = 1'b0;
        miss_seen = 1'b0;
      end
      if (mem_ack_i && !mem_req_i) begin
        complain("memory acked while mem_req_o was low");
      end
      if (mem_req_i) begin
        if (fl_addr_q.size() == 0) begin
          complain("mem_req_o rose with no fetch in flight");
        end else begin
          req_seen = 1'b1;
          if (mem_ack_i) begin
            a = fl_addr_q[0];
            e = fl_exp_q[0];
            compare("mem_nc_o", 32'(mem_nc_i), 32'(e.nc));
            compare("mem_addr_o", mem_addr_i,
                    e.nc ? {a[31:2], 2'b00} : {a[31:4], 4'b0000});
          end
        end
      end
      if (miss_i) begin
        miss_seen = 1'b1;
        if (!mem_ack_i) begin
          complain("miss_o pulsed outside an ack cycle");
        end
      end
      // acceptance moves the oldest expectation into flight
      if (req_i && ready_i) begin
        fl_addr_q.push_back(addr_i);
        fl_exp_q.push_back(pend_q.pop_front());
        fl_cycle_q.push_back(cycle);
      end
    end
  end

endmodule

// File: tb/icache_tb.sv
// testbench driving the instruction cache from a step trace, with a refill memory model
`timescale 1ns/1ns

module icache_tb;
  import icache_pkg::*;

  localparam int unsigned MaxSteps  = 256;
  localparam int unsigned ClkPeriod = 10;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  addr_t addr_i;
  logic  ready_o;
  logic  valid_o;
  word_t data_o;
  logic  en_i;
  logic  flush_i;
  logic  miss_o;
  logic  mem_req_o;
  addr_t mem_addr_o;
  logic  mem_nc_o;
  logic  mem_ack_i;
  logic  mem_rtrn_vld_i;
  line_t mem_rtrn_data_i;

  // trace steps, loaded before reset is released
  logic [127:0] step_op   [MaxSteps];
  logic [127:0] step_name [MaxSteps];
  addr_t        step_addr [MaxSteps];
  logic         step_flag [MaxSteps];
  int           num_steps    = 0;
  logic         trace_loaded = 1'b0;
  logic         trace_ok     = 1'b0;
  logic         cache_on     = 1'b0;
  logic         in_test      = 1'b0;
  int           seed;

  icache_top dut0 (
    .clk_i, .rst_ni, .req_i, .addr_i, .ready_o, .valid_o, .data_o, .en_i, .flush_i,
    .miss_o, .mem_req_o, .mem_addr_o, .mem_nc_o, .mem_ack_i, .mem_rtrn_vld_i,
    .mem_rtrn_data_i
  );

  icache_checker chk0 (
    .clk_i, .rst_ni, .req_i, .addr_i, .ready_i (ready_o), .valid_i (valid_o),
    .data_i (data_o), .miss_i (miss_o), .mem_req_i (mem_req_o), .mem_addr_i (mem_addr_o),
    .mem_nc_i (mem_nc_o), .mem_ack_i
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // refill memory model
  ////////////////////////////////////////////////////////////////////////////

  function automatic line_t line_at(input addr_t base);
    line_t l;
    for (int k = 0; k < WordsPerLine; k++) begin
      l[k*WordWidth +: WordWidth] = (base + addr_t'(4 * k)) ^ 32'h5a5a_0000;
    end
    return l;
  endfunction

  initial begin : memory_model
    int    ack_wait;
    int    rtrn_wait;
    addr_t base;
    seed            = 32'hdfe5_ed90;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o) begin
        // 1 to 4 cycles to ack, then 1 to 4 more to the return beat
        ack_wait  = 1 + int'($unsigned($random(seed)) % 4);
        rtrn_wait = 1 + int'($unsigned($random(seed)) % 4);
        repeat (ack_wait - 1) @(negedge clk_i);
        mem_ack_i = 1'b1;
        base      = {mem_addr_o[31:4], 4'b0000};
        @(negedge clk_i);
        mem_ack_i = 1'b0;
        repeat (rtrn_wait - 1) @(negedge clk_i);
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_data_i = line_at(base);
        @(negedge clk_i);
        mem_rtrn_vld_i  = 1'b0;
        mem_rtrn_data_i = '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // trace reader and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_trace();
    int               fd;
    int               rc;
    int               flag;
    logic [127:0]     tok;
    logic [127:0]     name;
    logic [8*128-1:0] rest;
    addr_t            a;
    fd = $fopen("tb/icache_trace.txt", "r");
    if (fd != 0) begin
      trace_ok = 1'b1;
      while ($fscanf(fd, "%s", tok) == 1 && num_steps < MaxSteps) begin
        if (tok == "#") begin
          rc = $fgets(rest, fd);
        end else if (tok == "test") begin
          rc = $fscanf(fd, "%s", name);
          step_op[num_steps]   = tok;
          step_name[num_steps] = name;
          num_steps++;
        end else begin
          rc = $fscanf(fd, "%h %d", a, flag);
          step_op[num_steps]   = tok;
          step_addr[num_steps] = a;
          step_flag[num_steps] = (flag != 0);
          num_steps++;
        end
      end
      $fclose(fd);
    end
    trace_loaded = 1'b1;
  endtask

  // wait until every issued fetch has answered
  task automatic drain();
    while (chk0.outstanding != 0) @(negedge clk_i);
  endtask

  task automatic issue_fetch(input addr_t addr, input logic miss_exp);
    chk0.expect_fetch(miss_exp, ~cache_on | addr[31]);
    req_i  = 1'b1;
    addr_i = addr;
    @(posedge clk_i);
    while (!ready_o) @(posedge clk_i);
    @(negedge clk_i);
    req_i  = 1'b0;
    addr_i = '0;
  endtask

  task automatic run_step(input int i);
    if (step_op[i] == "test") begin
      drain();
      if (in_test) begin
        chk0.finish_test();
      end
      chk0.start_test(step_name[i]);
      in_test = 1'b1;
    end else if (step_op[i] == "fetch") begin
      issue_fetch(step_addr[i], step_flag[i]);
    end else if (step_op[i] == "enable" || step_op[i] == "disable") begin
      drain();
      en_i     = (step_op[i] == "enable");
      cache_on = en_i;
      @(negedge clk_i);
    end else if (step_op[i] == "flush") begin
      drain();
      flush_i = 1'b1;
      @(negedge clk_i);
      flush_i = 1'b0;
    end else begin
      chk0.complain("unknown operation in the trace");
    end
  endtask

  initial begin : main
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    addr_i  = '0;
    en_i    = 1'b0;
    flush_i = 1'b0;
    load_trace();
    if (!trace_ok) begin
      $display("could not open the trace file tb/icache_trace.txt");
      $display("Some tests failed");
      $finish;
    end else begin
      repeat (4) @(negedge clk_i);
      rst_ni = 1'b1;
      for (int i = 0; i < num_steps; i++) begin
        run_step(i);
      end
      drain();
      if (in_test) begin
        chk0.finish_test();
      end
      chk0.report();
      if (chk0.error_count == 0 && chk0.num_tests > 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

  // budget of 20 cycles per trace step plus a margin for the sweeps
  initial begin : watchdog
    wait (trace_loaded);
    #((num_steps * 20 + 200) * ClkPeriod);
    $display("watchdog expired after %0d cycles with the trace unfinished",
             num_steps * 20 + 200);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: tb/icache_trace.txt
# each step is an operation, a hex address and the expected miss flag
# a test line opens a group, returned words are their byte address xor 5a5a0000
test disabled_fetch
fetch 00000100 0
fetch 00000104 0
fetch 00000100 0
fetch 80000040 0
test enable_and_hit
enable 00000000 0
fetch 00000100 1
fetch 00000104 0
fetch 00000108 0
fetch 0000010c 0
fetch 00000100 0
test back_to_back
fetch 00000200 1
fetch 00000210 1
fetch 00000200 0
fetch 00000204 0
fetch 00000208 0
fetch 0000020c 0
fetch 00000210 0
fetch 00000214 0
fetch 00000218 0
fetch 0000021c 0
test fill_ways
fetch 00001040 1
fetch 00002044 1
fetch 00003048 1
fetch 0000404c 1
fetch 00001040 0
fetch 00002040 0
fetch 00003040 0
fetch 00004040 0
fetch 00005048 1
test noncacheable
fetch 80000300 0
fetch 80000300 0
fetch 80000304 0
test flush
fetch 00000104 0
flush 00000000 0
fetch 00000104 1
fetch 00000108 0
test disable
disable 00000000 0
fetch 00000100 0
fetch 00000200 0
